// ==== Makefile ====
# Verilator build and run for the IWM testbench

SIM  := obj_dir/Viwm_tb
SRCS := $(wildcard src/*.sv verification/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module iwm_tb -f verilog.f -o Viwm_tb

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q '^test passed$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== src/iwm_bit_cell.sv ====
// Read data synchronizer and falling edge detect
// CLK divider, fclk / 2 for slow mode
// Windowed bit cell counter issuing '1' and '0' bit pulses

`timescale 1ns/100ps
`default_nettype none

module iwm_bit_cell #(
    parameter int WINDOW_OPEN = 7,
    parameter int TIMEOUT     = 21
) (
    input  logic fclk,
    input  logic rst_n,
    input  logic rddata,
    input  logic read_active,
    output logic lft1,
    output logic lft0
);

    localparam int CW = iwm_pkg::CELL_COUNT_W;

    typedef logic [CW-1:0] cnt_t;

    localparam cnt_t OPEN_CNT    = cnt_t'(WINDOW_OPEN);
    // Count held on the CLK before the one that times out
    localparam cnt_t LAST_CNT    = cnt_t'(TIMEOUT - 1);
    localparam cnt_t RESTART_CNT = cnt_t'(iwm_pkg::CELL_RESTART);

    logic [1:0] rd_sync;
    logic       rd_prev;
    logic       rd_fall;
    logic       clk_div;
    cnt_t       cell_cnt;

    // ==============================
    // Input synchronizer
    // ==============================
    // Line idles high, a '1' is a short low pulse
    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sync <= 2'b11;
            rd_prev <= 1'b1;
            rd_fall <= 1'b0;
        end else begin
            rd_sync <= {rd_sync[0], rddata};
            rd_prev <= rd_sync[1];
            // Registered one-cycle falling edge
            rd_fall <= rd_prev & ~rd_sync[1];
        end
    end

    // CLK enable, every other fclk
    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            clk_div <= 1'b0;
        end else begin
            clk_div <= ~clk_div;
        end
    end

    // ==============================
    // Bit cell counter
    // ==============================
    // Counts below OPEN_CNT form the dead zone
    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            cell_cnt <= '0;
            lft1     <= 1'b0;
            lft0     <= 1'b0;
        end else begin
            // Pulses last one fclk
            lft1 <= 1'b0;
            lft0 <= 1'b0;
            if (!read_active) begin
                cell_cnt <= '0;
            end else if (rd_fall) begin
                if (cell_cnt >= OPEN_CNT) begin
                    lft1 <= 1'b1;
                end
                // Any edge resyncs the cell, a runt adds no bit
                cell_cnt <= '0;
            end else if (clk_div) begin
                if (cell_cnt == LAST_CNT) begin
                    // No edge in the window
                    lft0     <= 1'b1;
                    cell_cnt <= RESTART_CNT;
                end else begin
                    cell_cnt <= cell_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/iwm_pkg.sv ====
// Shared definitions for the IWM read and control logic
// Byte and latch index types, state latch positions
// Bit cell window constants and the data register clear delay
// Register select codes and register bit positions

`default_nettype none

package iwm_pkg;

    // ==============================
    // Basic types
    // ==============================
    typedef logic [7:0] byte_t;
    typedef logic [2:0] state_idx_t;

    // Latch positions above the four phase bits
    localparam state_idx_t ST_MOTOR_ON  = 3'd4;
    localparam state_idx_t ST_DRIVE_SEL = 3'd5;
    localparam state_idx_t ST_L6        = 3'd6;
    localparam state_idx_t ST_L7        = 3'd7;

    // ==============================
    // Read timing
    // ==============================
    // Counted in CLK periods, slow mode with CLK = fclk / 2
    localparam int CELL_WINDOW_OPEN = 7;
    localparam int CELL_TIMEOUT     = 21;
    localparam int CELL_COUNT_W     = 6;
    // Reload after a timeout, so the next '0' comes one cell later
    localparam int CELL_RESTART     = 7;
    // Counted in fclk cycles
    localparam int CLEAR_FCLKS      = 14;

    // ==============================
    // Register decode
    // ==============================
    typedef enum logic [2:0] {
        SEL_ONES      = 3'd0,
        SEL_DATA      = 3'd1,
        SEL_STATUS    = 3'd2,
        SEL_HANDSHAKE = 3'd3,
        SEL_MODE_WR   = 3'd4,
        SEL_DATA_WR   = 3'd5
    } reg_sel_t;

    localparam int MODE_LATCH_BIT    = 0;
    localparam int STATUS_ENABLE_BIT = 5;
    localparam int STATUS_SENSE_BIT  = 7;

    localparam byte_t ONES_BYTE = 8'hFF;

endpackage

`default_nettype wire

// ==== src/iwm_read_latch.sv ====
// Serial to parallel read shift register, LSB first
// Read data register loaded when a one reaches the MSB
// MSB latch at /DEV fall and the delayed clear after a valid read

`timescale 1ns/100ps
`default_nettype none

module iwm_read_latch #(
    parameter int CLEAR_CYCLES = 14
) (
    input  logic              fclk,
    input  logic              rst_n,
    input  logic              lft1,
    input  logic              lft0,
    input  logic              read_active,
    input  logic              dev_sel_n,
    input  logic              dev_fall,
    input  logic              sel_data_next,
    input  logic              mode_latch,
    input  iwm_pkg::reg_sel_t reg_sel,
    output iwm_pkg::byte_t    read_byte
);

    localparam int CW = $clog2(CLEAR_CYCLES);

    typedef logic [CW-1:0] clr_cnt_t;

    localparam clr_cnt_t CLEAR_LAST = clr_cnt_t'(CLEAR_CYCLES - 1);

    // Low seven bits, a 1 shifted past bit 6 completes the byte
    logic [6:0]     shift_sr;
    iwm_pkg::byte_t sr_next;
    logic           shift_pulse;
    logic           byte_done;
    logic           msb_latch;
    logic           clear_pending;
    clr_cnt_t       clear_cnt;
    logic           valid_read;

    // ==============================
    // Shift register
    // ==============================
    assign shift_pulse = lft1 | lft0;
    assign sr_next     = {shift_sr, lft1};
    // Byte complete when this shift puts a 1 into the MSB
    assign byte_done   = shift_pulse & sr_next[7];

    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            shift_sr <= '0;
        end else if (!read_active) begin
            shift_sr <= '0;
        end else if (shift_pulse) begin
            // Cleared on the same edge that loads the data register
            if (sr_next[7]) begin
                shift_sr <= '0;
            end else begin
                shift_sr <= sr_next[6:0];
            end
        end
    end

    // ==============================
    // Data register and auto-clear
    // ==============================
    assign valid_read = (reg_sel == iwm_pkg::SEL_DATA) & ~dev_sel_n & msb_latch;

    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            read_byte     <= '0;
            msb_latch     <= 1'b0;
            clear_pending <= 1'b0;
            clear_cnt     <= '0;
        end else begin
            // Capture the MSB seen by this access
            // a byte landing on the same edge supplies its own MSB
            if (dev_fall && sel_data_next && mode_latch) begin
                msb_latch <= byte_done ? sr_next[7] : read_byte[7];
            end

            // Valid read starts the countdown
            if (valid_read && !clear_pending) begin
                clear_pending <= 1'b1;
                clear_cnt     <= '0;
            end

            if (clear_pending) begin
                if (clear_cnt == CLEAR_LAST) begin
                    read_byte     <= '0;
                    msb_latch     <= 1'b0;
                    clear_pending <= 1'b0;
                    clear_cnt     <= '0;
                end else begin
                    clear_cnt <= clear_cnt + 1'b1;
                end
            end

            // New byte wins over a pending clear
            if (byte_done) begin
                read_byte     <= sr_next;
                clear_pending <= 1'b0;
                clear_cnt     <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/iwm_registers.sv ====
// Write clock edge detect, rising edge of q3 OR /DEV
// Mode register and status byte assembly
// Data bus read multiplexer

`timescale 1ns/100ps
`default_nettype none

module iwm_registers (
    input  logic              fclk,
    input  logic              rst_n,
    input  logic              q3,
    input  logic              dev_sel_n,
    input  logic              sense,
    input  iwm_pkg::byte_t    data_in,
    input  iwm_pkg::reg_sel_t reg_sel,
    input  iwm_pkg::byte_t    state_bits,
    input  iwm_pkg::byte_t    read_byte,
    output logic              mode_latch,
    output iwm_pkg::byte_t    data_out
);

    logic           wr_clk;
    logic           wr_clk_d;
    logic           wr_clk_rise;
    iwm_pkg::byte_t mode_reg;
    iwm_pkg::byte_t status_byte;

    // ==============================
    // Write clock
    // ==============================
    // Bus data is sampled on the 0 to 1 change of q3 | /DEV
    assign wr_clk = q3 | dev_sel_n;

    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_clk_d <= 1'b1;
        end else begin
            wr_clk_d <= wr_clk;
        end
    end

    assign wr_clk_rise = ~wr_clk_d & wr_clk;

    // ==============================
    // Mode register
    // ==============================
    // Written only in the Mode Set state
    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            mode_reg <= '0;
        end else if (wr_clk_rise && reg_sel == iwm_pkg::SEL_MODE_WR) begin
            mode_reg <= data_in;
        end
    end

    assign mode_latch = mode_reg[iwm_pkg::MODE_LATCH_BIT];

    // Status byte
    // Low bits mirror the mode register, bit 6 reads 0
    always_comb begin
        status_byte                              = '0;
        status_byte[4:0]                         = mode_reg[4:0];
        // An enable is low whenever Motor-On is set
        status_byte[iwm_pkg::STATUS_ENABLE_BIT]  = state_bits[iwm_pkg::ST_MOTOR_ON];
        status_byte[iwm_pkg::STATUS_SENSE_BIT]   = sense;
    end

    // ==============================
    // Read multiplexer
    // ==============================
    always_comb begin
        case (reg_sel)
            iwm_pkg::SEL_DATA:      data_out = read_byte;
            iwm_pkg::SEL_STATUS:    data_out = status_byte;
            // No write side, so the handshake reads as idle
            iwm_pkg::SEL_HANDSHAKE: data_out = iwm_pkg::ONES_BYTE;
            default:                data_out = iwm_pkg::ONES_BYTE;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/iwm_state_latch.sv ====
// Device select falling edge detect
// Eight addressed state latches with phase and drive enable outputs
// Register select decode and its prediction past the pending update

`timescale 1ns/100ps
`default_nettype none

module iwm_state_latch (
    input  logic             fclk,
    input  logic             rst_n,
    input  logic             dev_sel_n,
    input  logic [3:0]       addr,
    output logic [3:0]       phase,
    output logic             enbl1_n,
    output logic             enbl2_n,
    output iwm_pkg::byte_t   state_bits,
    output iwm_pkg::reg_sel_t reg_sel,
    output logic             read_active,
    output logic             sel_data_next,
    output logic             dev_fall
);

    logic                  dev_sel_d;
    iwm_pkg::state_idx_t   latch_idx;
    logic                  next_l7;
    logic                  next_l6;
    logic                  next_motor;

    // L7, L6, Motor-On to register select
    function automatic iwm_pkg::reg_sel_t decode_sel(input logic l7, input logic l6,
                                                     input logic motor);
        iwm_pkg::reg_sel_t sel;
        case ({l7, l6})
            2'b00:   sel = motor ? iwm_pkg::SEL_DATA : iwm_pkg::SEL_ONES;
            2'b01:   sel = iwm_pkg::SEL_STATUS;
            2'b10:   sel = iwm_pkg::SEL_HANDSHAKE;
            default: sel = motor ? iwm_pkg::SEL_DATA_WR : iwm_pkg::SEL_MODE_WR;
        endcase
        return sel;
    endfunction

    // ==============================
    // State latches
    // ==============================
    // Previous /DEV level, idle high
    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            dev_sel_d <= 1'b1;
        end else begin
            dev_sel_d <= dev_sel_n;
        end
    end

    assign dev_fall  = dev_sel_d & ~dev_sel_n;
    // A3..A1 pick the latch, A0 is the value
    assign latch_idx = addr[3:1];

    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            state_bits <= '0;
        end else if (dev_fall) begin
            state_bits[latch_idx] <= addr[0];
        end
    end

    // Drive outputs, at most one enable low
    assign phase   = state_bits[3:0];
    assign enbl1_n = ~(state_bits[iwm_pkg::ST_MOTOR_ON] & ~state_bits[iwm_pkg::ST_DRIVE_SEL]);
    assign enbl2_n = ~(state_bits[iwm_pkg::ST_MOTOR_ON] & state_bits[iwm_pkg::ST_DRIVE_SEL]);

    // ==============================
    // Register select
    // ==============================
    assign reg_sel     = decode_sel(state_bits[iwm_pkg::ST_L7], state_bits[iwm_pkg::ST_L6],
                                    state_bits[iwm_pkg::ST_MOTOR_ON]);
    assign read_active = ~state_bits[iwm_pkg::ST_L7] & ~state_bits[iwm_pkg::ST_L6];

    // Bits as they stand after this edge, for the read latch MSB capture
    assign next_l7    = (dev_fall && latch_idx == iwm_pkg::ST_L7) ?
                        addr[0] : state_bits[iwm_pkg::ST_L7];
    assign next_l6    = (dev_fall && latch_idx == iwm_pkg::ST_L6) ?
                        addr[0] : state_bits[iwm_pkg::ST_L6];
    assign next_motor = (dev_fall && latch_idx == iwm_pkg::ST_MOTOR_ON) ?
                        addr[0] : state_bits[iwm_pkg::ST_MOTOR_ON];

    assign sel_data_next = (decode_sel(next_l7, next_l6, next_motor) == iwm_pkg::SEL_DATA);

endmodule

`default_nettype wire

// ==== src/iwm_top.sv ====
// IWM read and control top level
// Instances of state latch, bit cell extractor, read latch, registers
// Timing parameters taken from the package defaults

`timescale 1ns/100ps
`default_nettype none

module iwm_top #(
    parameter int WINDOW_OPEN  = iwm_pkg::CELL_WINDOW_OPEN,
    parameter int TIMEOUT      = iwm_pkg::CELL_TIMEOUT,
    parameter int CLEAR_CYCLES = iwm_pkg::CLEAR_FCLKS
) (
    input  logic           fclk,
    input  logic           rst_n,
    input  logic [3:0]     addr,
    input  logic           dev_sel_n,
    input  iwm_pkg::byte_t data_in,
    input  logic           q3,
    input  logic           rddata,
    input  logic           sense,
    output logic [3:0]     phase,
    output logic           enbl1_n,
    output logic           enbl2_n,
    output iwm_pkg::byte_t data_out
);

    iwm_pkg::byte_t    state_bits;
    iwm_pkg::reg_sel_t reg_sel;
    logic              read_active;
    logic              sel_data_next;
    logic              dev_fall;
    logic              lft1;
    logic              lft0;
    iwm_pkg::byte_t    read_byte;
    logic              mode_latch;

    // Bus side state latches and decode
    iwm_state_latch u_state_latch (
        .fclk          (fclk),
        .rst_n         (rst_n),
        .dev_sel_n     (dev_sel_n),
        .addr          (addr),
        .phase         (phase),
        .enbl1_n       (enbl1_n),
        .enbl2_n       (enbl2_n),
        .state_bits    (state_bits),
        .reg_sel       (reg_sel),
        .read_active   (read_active),
        .sel_data_next (sel_data_next),
        .dev_fall      (dev_fall)
    );

    // Serial read data to bit pulses
    iwm_bit_cell #(
        .WINDOW_OPEN (WINDOW_OPEN),
        .TIMEOUT     (TIMEOUT)
    ) u_bit_cell (
        .fclk        (fclk),
        .rst_n       (rst_n),
        .rddata      (rddata),
        .read_active (read_active),
        .lft1        (lft1),
        .lft0        (lft0)
    );

    // Bit pulses to bytes
    iwm_read_latch #(
        .CLEAR_CYCLES (CLEAR_CYCLES)
    ) u_read_latch (
        .fclk          (fclk),
        .rst_n         (rst_n),
        .lft1          (lft1),
        .lft0          (lft0),
        .read_active   (read_active),
        .dev_sel_n     (dev_sel_n),
        .dev_fall      (dev_fall),
        .sel_data_next (sel_data_next),
        .mode_latch    (mode_latch),
        .reg_sel       (reg_sel),
        .read_byte     (read_byte)
    );

    // Mode, status and the bus read path
    iwm_registers u_registers (
        .fclk       (fclk),
        .rst_n      (rst_n),
        .q3         (q3),
        .dev_sel_n  (dev_sel_n),
        .sense      (sense),
        .data_in    (data_in),
        .reg_sel    (reg_sel),
        .state_bits (state_bits),
        .read_byte  (read_byte),
        .mode_latch (mode_latch),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

// ==== verification/iwm_assertions.sv ====
// Concurrent assertions bound into the IWM top level
// Drive enables exclusive, bit pulses exclusive, mode register cleared in reset

`timescale 1ns/100ps
`default_nettype none

module iwm_assertions (
    input logic           fclk,
    input logic           rst_n,
    input logic           enbl1_n,
    input logic           enbl2_n,
    input logic           lft1,
    input logic           lft0,
    input iwm_pkg::byte_t mode_reg
);

    // Count of failed assertions
    int fail_count = 0;

    // Only one drive may be enabled at a time
    enables_exclusive: assert property (@(posedge fclk) disable iff (!rst_n)
        !(!enbl1_n && !enbl2_n))
        else begin
            $error("Both drive enables low");
            fail_count++;
        end

    // A bit cell yields a '1' or a '0', never both
    bit_pulses_exclusive: assert property (@(posedge fclk) disable iff (!rst_n)
        !(lft1 && lft0))
        else begin
            $error("lft1 and lft0 high together");
            fail_count++;
        end

    mode_reset: assert property (@(posedge fclk) !rst_n |-> (mode_reg == 8'h00))
        else begin
            $error("Mode register not zero during reset");
            fail_count++;
        end

endmodule

bind iwm_top iwm_assertions u_assertions (
    .fclk     (fclk),
    .rst_n    (rst_n),
    .enbl1_n  (enbl1_n),
    .enbl2_n  (enbl2_n),
    .lft1     (lft1),
    .lft0     (lft0),
    .mode_reg (u_registers.mode_reg)
);

`default_nettype wire

// ==== verification/iwm_tb.sv ====
// Testbench for the IWM read and control logic
// Clock, reset and bus access tasks for /DEV reads and mode writes
// Serial read data generator with an optional runt pulse
// Stimulus table with expected values, applied in one loop

`timescale 1ns/100ps
`default_nettype none

module iwm_tb;

    typedef enum int {OP_SET, OP_MODE, OP_SENSE, OP_READ, OP_BYTE, OP_CLEAR, OP_RUNT} op_t;

    localparam int MAX_ENTRIES = 64;
    // Worst case is two trailing zero cells after the last pulse
    localparam int BYTE_LIMIT  = 100;
    localparam int CLEAR_LIMIT = iwm_pkg::CLEAR_FCLKS + 8;

    logic           fclk;
    logic           rst_n;
    logic [3:0]     addr;
    logic           dev_sel_n;
    iwm_pkg::byte_t data_in;
    logic           q3;
    logic           rddata;
    logic           sense;
    logic [3:0]     phase;
    logic           enbl1_n;
    logic           enbl2_n;
    iwm_pkg::byte_t data_out;

    // Stimulus table
    int             tbl_test [MAX_ENTRIES];
    op_t            tbl_op   [MAX_ENTRIES];
    iwm_pkg::byte_t tbl_arg  [MAX_ENTRIES];
    iwm_pkg::byte_t tbl_exp  [MAX_ENTRIES];
    int             n_entries;
    string          test_name [1:6];

    int             check_count;
    int             error_count;
    int             test_checks;
    int             test_errors;
    int             total_errors;
    int             idx;
    logic [31:0]    lcg_state;
    iwm_pkg::byte_t prev_byte;

    iwm_top dut (
        .fclk      (fclk),
        .rst_n     (rst_n),
        .addr      (addr),
        .dev_sel_n (dev_sel_n),
        .data_in   (data_in),
        .q3        (q3),
        .rddata    (rddata),
        .sense     (sense),
        .phase     (phase),
        .enbl1_n   (enbl1_n),
        .enbl2_n   (enbl2_n),
        .data_out  (data_out)
    );

    // 4 ns fclk
    initial begin
        fclk = 1'b0;
        forever begin
            #2 fclk = ~fclk;
        end
    end

    // ==============================
    // Helpers
    // ==============================
    // Bits 7, 4 and 1 set keep zero runs at two cells or less
    function automatic iwm_pkg::byte_t lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16] | 8'h92;
    endfunction

    // Random byte unlike the one before, so a poll cannot match stale data
    function automatic iwm_pkg::byte_t fresh_byte();
        iwm_pkg::byte_t b;
        b = lcg_byte();
        while (b == prev_byte) begin
            b = lcg_byte();
        end
        return b;
    endfunction

    task automatic add_entry(input int test, input op_t op, input iwm_pkg::byte_t arg,
                             input iwm_pkg::byte_t exp);
        tbl_test[n_entries] = test;
        tbl_op[n_entries]   = op;
        tbl_arg[n_entries]  = arg;
        tbl_exp[n_entries]  = exp;
        n_entries++;
        if (op == OP_BYTE || op == OP_RUNT) begin
            prev_byte = arg;
        end
    endtask

    // Random read byte, optionally followed by a clearing /DEV read at address 14
    task automatic add_random(input int test, input op_t op, input logic with_clear);
        iwm_pkg::byte_t b;
        b = fresh_byte();
        add_entry(test, op, b, b);
        if (with_clear) begin
            add_entry(test, OP_CLEAR, 8'h0E, b);
        end
    endtask

    task automatic check_value(input string name, input iwm_pkg::byte_t actual,
                               input iwm_pkg::byte_t expected);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = 8'h%h, expected 8'h%h",
                     $time, name, actual, expected);
            error_count++;
            test_errors++;
        end
    endtask

    // A poll that reached its target value
    task automatic count_pass();
        check_count++;
        test_checks++;
    endtask

    task automatic note_timeout(input string what);
        check_count++;
        test_checks++;
        error_count++;
        test_errors++;
        $display("Timeout at %0t ns, %s", $time, what);
    endtask

    // ==============================
    // Bus and read data drivers
    // ==============================
    // One /DEV cycle, A0 rewrites the addressed latch
    task automatic bus_access(input logic [3:0] a, output iwm_pkg::byte_t value);
        @(negedge fclk);
        addr      = a;
        dev_sel_n = 1'b0;
        repeat (2) @(negedge fclk);
        value     = data_out;
        dev_sel_n = 1'b1;
        @(negedge fclk);
    endtask

    // Mode write at address 15, L7 stays set
    task automatic write_mode(input iwm_pkg::byte_t value);
        @(negedge fclk);
        addr      = 4'hF;
        data_in   = value;
        dev_sel_n = 1'b0;
        @(negedge fclk);
        q3 = 1'b0;
        repeat (2) @(negedge fclk);
        // q3 rising with /DEV low strobes the data
        q3 = 1'b1;
        repeat (2) @(negedge fclk);
        dev_sel_n = 1'b1;
        @(negedge fclk);
    endtask

    // MSB first, 28 fclk per cell, a '1' is a 7 fclk low pulse
    task automatic send_byte(input iwm_pkg::byte_t value, input logic with_runt);
        int i;
        @(negedge fclk);
        // Idle cell so the first edge is past the dead zone
        rddata = 1'b1;
        repeat (28) @(negedge fclk);
        for (i = 7; i >= 0; i--) begin
            if (value[i] && with_runt && i == 7) begin
                // Short pulse, then a runt edge 4 fclk after it
                rddata = 1'b0;
                repeat (2) @(negedge fclk);
                rddata = 1'b1;
                repeat (2) @(negedge fclk);
                rddata = 1'b0;
                repeat (2) @(negedge fclk);
                rddata = 1'b1;
                repeat (22) @(negedge fclk);
            end else if (value[i]) begin
                rddata = 1'b0;
                repeat (7) @(negedge fclk);
                rddata = 1'b1;
                repeat (21) @(negedge fclk);
            end else begin
                repeat (28) @(negedge fclk);
            end
        end
    endtask

    task automatic await_data(input iwm_pkg::byte_t expected, input int limit,
                              output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < limit) begin
            @(negedge fclk);
            if (data_out === expected) begin
                seen = 1'b1;
            end
            n++;
        end
    endtask

    // ==============================
    // Table
    // ==============================
    task automatic build_table();
        test_name[1] = "state latches";
        test_name[2] = "mode and status";
        test_name[3] = "decode";
        test_name[4] = "read bytes";
        test_name[5] = "auto-clear";
        test_name[6] = "runt rejection";
        // SET expects {2'b00, enbl2_n, enbl1_n, phase}
        add_entry(1, OP_SET, 8'h01, 8'h31);
        add_entry(1, OP_SET, 8'h03, 8'h33);
        add_entry(1, OP_SET, 8'h05, 8'h37);
        add_entry(1, OP_SET, 8'h07, 8'h3F);
        add_entry(1, OP_SET, 8'h00, 8'h3E);
        add_entry(1, OP_SET, 8'h04, 8'h3A);
        add_entry(1, OP_SET, 8'h09, 8'h2A);
        add_entry(1, OP_SET, 8'h0B, 8'h1A);
        add_entry(1, OP_SET, 8'h08, 8'h3A);
        add_entry(1, OP_SET, 8'h0A, 8'h3A);
        add_entry(1, OP_SET, 8'h02, 8'h38);
        add_entry(1, OP_SET, 8'h06, 8'h30);
        // Mode Set state, then status state with Motor-On off and on
        add_entry(2, OP_SET, 8'h0F, 8'h30);
        add_entry(2, OP_SET, 8'h0D, 8'h30);
        add_entry(2, OP_MODE, 8'h07, 8'h00);
        add_entry(2, OP_SET, 8'h0E, 8'h30);
        add_entry(2, OP_SENSE, 8'h01, 8'h00);
        add_entry(2, OP_READ, 8'h0E, 8'h87);
        add_entry(2, OP_SENSE, 8'h00, 8'h00);
        add_entry(2, OP_READ, 8'h0E, 8'h07);
        add_entry(2, OP_SET, 8'h09, 8'h20);
        add_entry(2, OP_SENSE, 8'h01, 8'h00);
        add_entry(2, OP_READ, 8'h09, 8'hA7);
        add_entry(2, OP_SENSE, 8'h00, 8'h00);
        add_entry(2, OP_READ, 8'h09, 8'h27);
        // 0,0,0 then 1,0,x
        add_entry(3, OP_SET, 8'h08, 8'h30);
        add_entry(3, OP_SET, 8'h0C, 8'h30);
        add_entry(3, OP_READ, 8'h0C, iwm_pkg::ONES_BYTE);
        add_entry(3, OP_SET, 8'h0F, 8'h30);
        add_entry(3, OP_READ, 8'h0F, iwm_pkg::ONES_BYTE);
        add_entry(3, OP_SET, 8'h09, 8'h20);
        add_entry(3, OP_READ, 8'h0F, iwm_pkg::ONES_BYTE);
        // Read state, L7 = L6 = 0 with Motor-On set
        add_entry(4, OP_SET, 8'h0E, 8'h20);
        add_entry(4, OP_BYTE, 8'hD5, 8'hD5);
        add_entry(4, OP_BYTE, 8'h96, 8'h96);
        add_random(4, OP_BYTE, 1'b0);
        add_random(4, OP_BYTE, 1'b0);
        add_random(4, OP_BYTE, 1'b0);
        add_random(4, OP_BYTE, 1'b0);
        add_random(5, OP_BYTE, 1'b1);
        add_random(5, OP_BYTE, 1'b1);
        // The runt restarts the cell 4 fclk late, short zero runs decode the same
        add_entry(6, OP_RUNT, 8'hB5, 8'hB5);
        add_entry(6, OP_CLEAR, 8'h0E, 8'hB5);
        add_random(6, OP_RUNT, 1'b1);
    endtask

    task automatic apply_entry(input int k);
        iwm_pkg::byte_t value;
        logic           seen;
        case (tbl_op[k])
            OP_SET: begin
                bus_access(tbl_arg[k][3:0], value);
                check_value("{enbl2_n, enbl1_n, phase}",
                            {2'b00, enbl2_n, enbl1_n, phase}, tbl_exp[k]);
            end
            OP_MODE: begin
                write_mode(tbl_arg[k]);
            end
            OP_SENSE: begin
                @(negedge fclk);
                sense = tbl_arg[k][0];
            end
            OP_READ: begin
                bus_access(tbl_arg[k][3:0], value);
                check_value("data_out", value, tbl_exp[k]);
            end
            OP_BYTE, OP_RUNT: begin
                send_byte(tbl_arg[k], tbl_op[k] == OP_RUNT);
                await_data(tbl_exp[k], BYTE_LIMIT, seen);
                if (seen) begin
                    count_pass();
                end else begin
                    note_timeout($sformatf("data_out never showed 8'h%h, last 8'h%h",
                                           tbl_exp[k], data_out));
                end
            end
            OP_CLEAR: begin
                @(negedge fclk);
                addr      = tbl_arg[k][3:0];
                dev_sel_n = 1'b0;
                @(negedge fclk);
                check_value("data_out", data_out, tbl_exp[k]);
                // Valid read, /DEV held low until the register clears
                await_data(8'h00, CLEAR_LIMIT, seen);
                if (seen) begin
                    count_pass();
                end else begin
                    note_timeout($sformatf("data_out not cleared, still 8'h%h", data_out));
                end
                dev_sel_n = 1'b1;
            end
            default: begin
                note_timeout("unknown table operation");
            end
        endcase
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        rst_n       = 1'b0;
        addr        = 4'h0;
        dev_sel_n   = 1'b1;
        data_in     = 8'h00;
        q3          = 1'b1;
        rddata      = 1'b1;
        sense       = 1'b0;
        lcg_state   = 32'd98;
        prev_byte   = 8'h00;
        n_entries   = 0;
        check_count = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        build_table();
        repeat (16) @(negedge fclk);
        rst_n = 1'b1;
        @(negedge fclk);

        for (idx = 0; idx < n_entries; idx++) begin
            apply_entry(idx);
            if (idx == n_entries - 1 || tbl_test[idx + 1] != tbl_test[idx]) begin
                $display("Test %0d, %s: %0d checks, %0d errors", tbl_test[idx],
                         test_name[tbl_test[idx]], test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end

        total_errors = error_count + dut.u_assertions.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count,
                 error_count, dut.u_assertions.fail_count);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/iwm_pkg.sv
src/iwm_state_latch.sv
src/iwm_bit_cell.sv
src/iwm_read_latch.sv
src/iwm_registers.sv
src/iwm_top.sv
verification/iwm_assertions.sv
verification/iwm_tb.sv
